/* flist.f */
+incdir+.
cache_pkg.sv
cache_wtbuf.sv
cache_front_end.sv
cache_memory.sv
cache_back_end.sv
cache_control.sv
cache_top.sv
cache_checker.sv
cache_monitor.sv
tb_cache.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache \
   -f flist.f -o sim_cache > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

# A run that aborts, such as on an assertion, counts as a failure
./obj_dir/sim_cache > sim.log 2>&1 || echo "=== FAIL ===" >> sim.log
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"

/* tb_cache.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module tb_cache import cache_pkg::*; ();

   localparam int N_OPS     = 400;
   localparam int OP_CYCLES = 80;                 // Cycle budget per operation
   localparam int CLK_NS    = 10;

   logic               clk = 1'b0;
   logic               rst;
   logic               req;
   fe_addr_t           addr;
   data_t              wdata;
   strb_t              wstrb;
   data_t              rdata;
   logic               ack;
   logic               be_req;
   logic [`ADDR_W-1:0] be_addr;
   data_t              be_wdata;
   strb_t              be_wstrb;
   data_t              be_rdata = '0;
   logic               be_ack = 1'b0;
   logic               invalidate_in;
   logic               invalidate_out;
   logic               wtb_empty_in;
   logic               wtb_empty_out;
   int                 error_count;
   int                 check_count;

   data_t       be_mem [2**(`ADDR_W-`NBYTES_W)];  // Back-end memory, word indexed
   logic [15:0] stim_lfsr;
   logic [15:0] mem_lfsr;
   int          wait_left;

   cache_top i_dut (.*);

   cache_monitor i_monitor (.*);

   always #(CLK_NS / 2) clk = ~clk;

   // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic draw(inout logic [15:0] st, input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = st[0];
         st   = lfsr_step(st);                    // One step per bit
      end
   endtask

   function automatic data_t fill_word(input word_addr_t w);
      return {2'b10, w, 2'b01, ~w};
   endfunction

   function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t s);
      data_t r;
      r = old;
      for (int b = 0; b < `NBYTES; b++) if (s[b]) r[8*b +: 8] = nw[8*b +: 8];
      return r;
   endfunction

   // 64 words on 4 lines with 4 tags each, so lines get evicted
   function automatic fe_addr_t data_addr(input logic [5:0] r);
      return {1'b0, 6'b0, r[5:4], 2'b00, r[3:0]};
   endfunction

   function automatic fe_addr_t ctrl_reg_addr(input ctrl_addr_t off);
      return {1'b1, 10'b0, off};
   endfunction

   // One request, accepted on the next edge, then wait for ack
   task automatic bus_access(input fe_addr_t a, input data_t d, input strb_t s);
      req   <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= s;
      @(posedge clk);
      req <= 1'b0;
      @(posedge clk);
      while (!ack) @(posedge clk);
   endtask

   // Back-end memory with 0 to 3 wait cycles per beat
   always @(posedge clk) begin
      logic [31:0] w;
      if (rst) begin
         be_ack   <= 1'b0;
         wait_left = -1;
         mem_lfsr  = 16'd30535;
         for (int i = 0; i < 2**(`ADDR_W-`NBYTES_W); i++) be_mem[i] = fill_word(word_addr_t'(i));
      end else if (be_ack) begin
         be_ack <= 1'b0;                          // Single-cycle ack
      end else if (be_req) begin
         if (wait_left < 0) begin
            draw(mem_lfsr, 2, w);
            wait_left = int'(w[1:0]);
         end
         if (wait_left == 0) begin
            be_ack   <= 1'b1;
            wait_left = -1;
            if (be_wstrb == '0) be_rdata <= be_mem[be_addr[`ADDR_W-1:`NBYTES_W]];
            else be_mem[be_addr[`ADDR_W-1:`NBYTES_W]] =
               merge_bytes(be_mem[be_addr[`ADDR_W-1:`NBYTES_W]], be_wdata, be_wstrb);
         end else begin
            wait_left--;
         end
      end
   end

   initial begin
      #(N_OPS * OP_CYCLES * CLK_NS);
      $display("Timeout: run did not finish within %0d ns", N_OPS * OP_CYCLES * CLK_NS);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      logic [31:0] kind;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] s;
      logic [31:0] e;
      rst           = 1'b1;
      req           = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      invalidate_in = 1'b0;
      wtb_empty_in  = 1'b1;
      stim_lfsr     = 16'd30535;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int n = 0; n < N_OPS; n++) begin
         draw(stim_lfsr, 4, kind);
         draw(stim_lfsr, 3, e);
         wtb_empty_in <= (e[2:0] != 3'd0);        // Downstream sometimes busy
         if (kind < 7) begin
            draw(stim_lfsr, 6, a);
            bus_access(data_addr(a[5:0]), '0, '0);
         end else if (kind < 13) begin
            draw(stim_lfsr, 6, a);
            draw(stim_lfsr, 32, d);
            draw(stim_lfsr, 4, s);
            if (s[3:0] == 4'd0) s[0] = 1'b1;      // Zero strobe would be a read
            bus_access(data_addr(a[5:0]), d, s[3:0]);
         end else if (kind == 13) begin
            draw(stim_lfsr, 2, a);
            bus_access(ctrl_reg_addr(ctrl_addr_t'(a[1:0])), '0, '0);
         end else if (kind == 14) begin
            draw(stim_lfsr, 1, a);
            bus_access(ctrl_reg_addr(a[0] ? `CTRL_INVALIDATE : `CTRL_RST_CNT), '0, 4'hf);
         end else begin
            invalidate_in <= 1'b1;                // Pin pulse between requests
            @(posedge clk);
            invalidate_in <= 1'b0;
         end
      end
      for (int k = 0; k < 4; k++) bus_access(ctrl_reg_addr(ctrl_addr_t'(k)), '0, '0);
      bus_access(ctrl_reg_addr(`CTRL_RST_CNT), '0, 4'hf);
      bus_access(ctrl_reg_addr(`CTRL_READ_MISS), '0, '0);
      wtb_empty_in <= 1'b1;
      @(posedge clk);
      while (!wtb_empty_out) @(posedge clk);     // All writes retired
      @(posedge clk);
      $display("Run complete: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* cache_monitor.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_monitor import cache_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               req,
   input  fe_addr_t           addr,
   input  data_t              wdata,
   input  strb_t              wstrb,
   input  data_t              rdata,
   input  logic               ack,
   input  logic               be_req,
   input  logic [`ADDR_W-1:0] be_addr,
   input  data_t              be_wdata,
   input  strb_t              be_wstrb,
   input  logic               be_ack,
   input  logic               invalidate_in,
   input  logic               invalidate_out,
   input  logic               wtb_empty_in,
   input  logic               wtb_empty_out,
   output int                 error_count,
   output int                 check_count
);

   logic [7:0]         ref_bytes [2**`ADDR_W];    // Byte-level memory image
   logic [15:0]        valid_sh;                  // Tag/valid shadow, one per line
   tag_t               tag_sh [16];
   cnt_t               cnt [4];                   // Same order as the counter registers
   logic               pend;
   fe_addr_t           p_addr;
   data_t              p_wdata;
   strb_t              p_wstrb;
   logic [51:0]        wq [$];                    // Writes owed to the back end
   logic [`ADDR_W-1:0] beats [$];                 // Refill beat addresses seen

   function automatic data_t fill_word(input word_addr_t w);
      return {2'b10, w, 2'b01, ~w};
   endfunction

   function automatic data_t ref_read(input word_addr_t w);
      data_t d;
      for (int b = 0; b < `NBYTES; b++) d[8*b +: 8] = ref_bytes[int'(w) * `NBYTES + b];
      return d;
   endfunction

   function automatic void ref_write(input word_addr_t w, input data_t d, input strb_t s);
      for (int b = 0; b < `NBYTES; b++) begin
         if (s[b]) ref_bytes[int'(w) * `NBYTES + b] = d[8*b +: 8];  // Only strobed bytes
      end
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic note_failure(input string what);
      error_count++;
      $display("Error at t=%0t: %s", $time, what);
   endtask

   always @(posedge clk) begin
      word_addr_t w;
      index_t     idx;
      tag_t       tg;
      logic       hit;
      logic       exp_inv;
      if (rst) begin
         error_count = 0;
         check_count = 0;
         pend        = 1'b0;
         valid_sh    = '0;
         wq.delete();
         beats.delete();
         for (int k = 0; k < 4; k++) cnt[k] = '0;
         for (int i = 0; i < 2**(`ADDR_W-`NBYTES_W); i++) begin
            ref_write(word_addr_t'(i), fill_word(word_addr_t'(i)), '1);
         end
      end else begin
         // Empty chain, judged on values from before this edge
         if (wtb_empty_out && !wtb_empty_in) note_failure("wtb_empty_out high with wtb_empty_in low");
         if (wtb_empty_out && wq.size() != 0) note_failure("wtb_empty_out high with writes owed");
         exp_inv = invalidate_in || (ack && pend && p_addr[`ADDR_W-`NBYTES_W] && (p_wstrb != '0)
                   && (p_addr[`CTRL_ADDR_W-1:0] == `CTRL_INVALIDATE));
         if (exp_inv || invalidate_out) check("invalidate_out", invalidate_out, exp_inv);
         if (be_req && be_ack) begin
            if (be_wstrb == '0) beats.push_back(be_addr);
            else if (wq.size() == 0) note_failure("back-end write with no write issued");
            else check("be_addr/be_wdata/be_wstrb", {be_addr, be_wdata, be_wstrb}, wq.pop_front());
         end
         if (ack && !pend) note_failure("ack with no request outstanding");
         if (ack && pend) begin
            w   = p_addr[`ADDR_W-`NBYTES_W-1:0];
            idx = w[`WORD_OFFSET_W +: `NLINES_W];
            tg  = w[`ADDR_W-`NBYTES_W-1 -: `TAG_W];
            hit = valid_sh[idx] && (tag_sh[idx] == tg);
            if (p_addr[`ADDR_W-`NBYTES_W]) begin
               if (p_wstrb == '0 && p_addr[`CTRL_ADDR_W-1:0] < 4) begin
                  check("ctrl_rdata", rdata, cnt[p_addr[1:0]]);
               end else if (p_wstrb != '0 && p_addr[`CTRL_ADDR_W-1:0] == `CTRL_RST_CNT) begin
                  for (int k = 0; k < 4; k++) cnt[k] = '0;
               end
            end else if (p_wstrb == '0) begin
               check("rdata", rdata, ref_read(w));
               check("refill beat count", beats.size(), hit ? 0 : 4);
               if (!hit) begin
                  foreach (beats[k]) begin
                     check("be_addr", beats[k], {w[`ADDR_W-`NBYTES_W-1:`WORD_OFFSET_W], 4'b0} + 4*k);
                  end
                  valid_sh[idx] = 1'b1;            // Read miss allocates
                  tag_sh[idx]   = tg;
                  cnt[1]++;
               end else begin
                  cnt[0]++;
               end
            end else begin
               ref_write(w, p_wdata, p_wstrb);
               wq.push_back({w, 2'b00, p_wdata, p_wstrb});
               if (hit) cnt[2]++;
               else cnt[3]++;                     // No allocate on write miss
            end
            beats.delete();
            pend = 1'b0;
         end
         if (invalidate_out) valid_sh = '0;
         if (req && !pend) begin                 // Front end takes it this edge
            pend    = 1'b1;
            p_addr  = addr;
            p_wdata = wdata;
            p_wstrb = wstrb;
         end
      end
   end

endmodule

/* cache_checker.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_checker (
   input logic               clk,
   input logic               rst,
   input logic               req,
   input logic               ack,
   input logic               be_req,
   input logic               be_ack,
   input logic [`ADDR_W-1:0] be_addr,
   input logic [`NBYTES-1:0] be_wstrb,
   input logic               wtb_empty_in,
   input logic               wtb_empty_out
);

   logic in_flight;                        // Host request taken and not yet answered

   always_ff @(posedge clk) begin
      if (rst) begin
         in_flight <= 1'b0;
      end else if (req && (!in_flight || ack)) begin
         in_flight <= 1'b1;                // Next request may ride on the ack cycle
      end else if (ack) begin
         in_flight <= 1'b0;
      end
   end

   // Back-end transaction held steady until the memory answers
   assert property (@(posedge clk) disable iff (rst)
      be_req && !be_ack |=> be_req && $stable(be_addr) && $stable(be_wstrb))
      else $error("be_req or be_addr changed before be_ack");

   // Ack only answers a request taken on the host port
   assert property (@(posedge clk) disable iff (rst)
      ack |-> in_flight)
      else $error("ack raised with no host request outstanding");

   // Refill reads only run on a drained buffer
   assert property (@(posedge clk) disable iff (rst)
      be_req && (be_wstrb == '0) && wtb_empty_in |-> wtb_empty_out)
      else $error("refill read issued while the write buffer holds entries");

endmodule

bind cache_top cache_checker i_checker (
   .clk(clk), .rst(rst), .req(req), .ack(ack),
   .be_req(be_req), .be_ack(be_ack), .be_addr(be_addr), .be_wstrb(be_wstrb),
   .wtb_empty_in(wtb_empty_in), .wtb_empty_out(wtb_empty_out)
);

/* cache_top.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_top import cache_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   // Front-end native port
   input  logic       req,
   input  fe_addr_t   addr,
   input  data_t      wdata,
   input  strb_t      wstrb,
   output data_t      rdata,
   output logic       ack,
   // Back-end native port
   output logic       be_req,
   output logic [`ADDR_W-1:0] be_addr,
   output data_t      be_wdata,
   output strb_t      be_wstrb,
   input  data_t      be_rdata,
   input  logic       be_ack,
   // Invalidate and buffer-empty chain
   input  logic       invalidate_in,
   output logic       invalidate_out,
   input  logic       wtb_empty_in,
   output logic       wtb_empty_out
);

   logic       data_req, data_ack, ctrl_req, ctrl_ack, ctrl_invalidate;
   word_addr_t addr_reg, wtb_addr;
   data_t      wdata_reg, data_rdata, ctrl_rdata, wtb_data, read_rdata;
   strb_t      wstrb_reg, wtb_strb;
   ctrl_addr_t ctrl_addr;
   logic       wtb_empty, wtb_full, wtb_pop;
   logic       replace_req, read_valid, replace_done;
   offset_t    read_offset;
   logic [`ADDR_W-`NBYTES_W-1:`WORD_OFFSET_W] replace_addr;
   logic       read_hit, read_miss, write_hit, write_miss;

   assign invalidate_out = ctrl_invalidate | invalidate_in;  // Also drops own lines
   assign wtb_empty_out  = wtb_empty & wtb_empty_in;

   cache_front_end i_front_end (
      .clk(clk), .rst(rst), .req(req), .addr(addr), .wdata(wdata), .wstrb(wstrb),
      .rdata(rdata), .ack(ack), .data_rdata(data_rdata), .data_ack(data_ack),
      .data_req(data_req), .addr_reg(addr_reg), .wdata_reg(wdata_reg),
      .wstrb_reg(wstrb_reg), .ctrl_rdata(ctrl_rdata), .ctrl_ack(ctrl_ack),
      .ctrl_req(ctrl_req), .ctrl_addr(ctrl_addr)
   );

   cache_memory i_memory (
      .clk(clk), .rst(rst), .data_req(data_req), .addr_reg(addr_reg),
      .wdata_reg(wdata_reg), .wstrb_reg(wstrb_reg), .data_rdata(data_rdata),
      .data_ack(data_ack), .invalidate(invalidate_out), .replace_req(replace_req),
      .replace_addr(replace_addr), .read_valid(read_valid), .read_offset(read_offset),
      .read_rdata(read_rdata), .replace_done(replace_done), .wtb_pop(wtb_pop),
      .wtb_empty(wtb_empty), .wtb_full(wtb_full), .wtb_data(wtb_data),
      .wtb_addr(wtb_addr), .wtb_strb(wtb_strb), .read_hit(read_hit),
      .read_miss(read_miss), .write_hit(write_hit), .write_miss(write_miss)
   );

   cache_back_end i_back_end (
      .clk(clk), .rst(rst), .wtb_empty(wtb_empty), .wtb_addr(wtb_addr),
      .wtb_data(wtb_data), .wtb_strb(wtb_strb), .wtb_pop(wtb_pop),
      .replace_req(replace_req), .replace_addr(replace_addr), .read_valid(read_valid),
      .read_offset(read_offset), .read_rdata(read_rdata), .replace_done(replace_done),
      .be_req(be_req), .be_addr(be_addr), .be_wdata(be_wdata), .be_wstrb(be_wstrb),
      .be_rdata(be_rdata), .be_ack(be_ack)
   );

   cache_control i_control (
      .clk(clk), .rst(rst), .ctrl_req(ctrl_req), .ctrl_addr(ctrl_addr),
      .wstrb_reg(wstrb_reg), .wtb_empty(wtb_empty), .wtb_full(wtb_full),
      .read_hit(read_hit), .read_miss(read_miss), .write_hit(write_hit),
      .write_miss(write_miss), .ctrl_rdata(ctrl_rdata), .ctrl_ack(ctrl_ack),
      .invalidate(ctrl_invalidate)
   );

endmodule

/* cache_control.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_control import cache_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       ctrl_req,
   input  ctrl_addr_t ctrl_addr,
   input  strb_t      wstrb_reg,
   // Cache status and events
   input  logic       wtb_empty,
   input  logic       wtb_full,
   input  logic       read_hit,
   input  logic       read_miss,
   input  logic       write_hit,
   input  logic       write_miss,
   output data_t      ctrl_rdata,
   output logic       ctrl_ack,
   output logic       invalidate
);

   cnt_t read_hit_cnt;
   cnt_t read_miss_cnt;
   cnt_t write_hit_cnt;
   cnt_t write_miss_cnt;

   logic ctrl_write;
   logic rst_cnt;

   assign ctrl_ack   = ctrl_req;                  // Every access done in one cycle
   assign ctrl_write = ctrl_req & (|wstrb_reg);
   assign rst_cnt    = ctrl_write & (ctrl_addr == `CTRL_RST_CNT);
   assign invalidate = ctrl_write & (ctrl_addr == `CTRL_INVALIDATE);  // One cycle pulse

   // Event counters
   always_ff @(posedge clk) begin
      if (rst || rst_cnt) begin
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end else begin
         if (read_hit)   read_hit_cnt   <= read_hit_cnt + 1'b1;
         if (read_miss)  read_miss_cnt  <= read_miss_cnt + 1'b1;
         if (write_hit)  write_hit_cnt  <= write_hit_cnt + 1'b1;
         if (write_miss) write_miss_cnt <= write_miss_cnt + 1'b1;
      end
   end

   // Register read-back
   always_comb begin
      ctrl_rdata = '0;
      case (ctrl_addr)
         `CTRL_READ_HIT:   ctrl_rdata = read_hit_cnt;
         `CTRL_READ_MISS:  ctrl_rdata = read_miss_cnt;
         `CTRL_WRITE_HIT:  ctrl_rdata = write_hit_cnt;
         `CTRL_WRITE_MISS: ctrl_rdata = write_miss_cnt;
         `CTRL_WTB_EMPTY:  ctrl_rdata = data_t'(wtb_empty);
         `CTRL_WTB_FULL:   ctrl_rdata = data_t'(wtb_full);
         default:          ctrl_rdata = '0;  // Command offsets read as zero
      endcase
   end

endmodule

/* cache_back_end.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_back_end import cache_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   // Write-through buffer head
   input  logic       wtb_empty,
   input  word_addr_t wtb_addr,
   input  data_t      wtb_data,
   input  strb_t      wtb_strb,
   output logic       wtb_pop,
   // Refill channel
   input  logic       replace_req,
   input  logic [`ADDR_W-`NBYTES_W-1:`WORD_OFFSET_W] replace_addr,
   output logic       read_valid,
   output offset_t    read_offset,
   output data_t      read_rdata,
   output logic       replace_done,
   // Native memory port
   output logic       be_req,
   output logic [`ADDR_W-1:0] be_addr,
   output data_t      be_wdata,
   output strb_t      be_wstrb,
   input  data_t      be_rdata,
   input  logic       be_ack
);

   be_state_t state;
   offset_t   beat;                       // Refill word being fetched

   logic start_read;
   logic start_write;

   // Refill first, the buffer is empty whenever one is requested
   assign start_read  = (state == BE_IDLE) & replace_req;
   assign start_write = (state == BE_IDLE) & ~replace_req & ~wtb_empty;

   assign wtb_pop      = (state == BE_WRITE) & be_ack;  // Entry retired on ack
   assign read_valid   = (state == BE_READ) & be_ack;
   assign read_offset  = beat;
   assign read_rdata   = be_rdata;
   assign replace_done = read_valid & (&beat);          // With the last beat

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= BE_IDLE;
         be_req <= 1'b0;
         beat   <= '0;
      end else begin
         case (state)
            BE_IDLE: begin
               beat <= '0;
               if (start_read) begin
                  state  <= BE_READ;
                  be_req <= 1'b1;
               end else if (start_write) begin
                  state  <= BE_WRITE;
                  be_req <= 1'b1;
               end
            end
            BE_WRITE: begin
               if (be_ack) begin            // One entry per transaction
                  state  <= BE_IDLE;
                  be_req <= 1'b0;
               end
            end
            BE_READ: begin
               if (be_ack) begin
                  beat <= beat + 1'b1;
                  if (&beat) begin
                     state  <= BE_IDLE;
                     be_req <= 1'b0;
                  end
               end
            end
            default: state <= BE_IDLE;
         endcase
      end
   end

   // Transaction fields, loaded with be_req and held until be_ack
   always_ff @(posedge clk) begin
      if (start_read) begin
         be_addr  <= {replace_addr, offset_t'(0), {`NBYTES_W{1'b0}}};
         be_wstrb <= '0;                    // Zero strobe reads
      end else if (start_write) begin
         be_addr  <= {wtb_addr, {`NBYTES_W{1'b0}}};
         be_wdata <= wtb_data;
         be_wstrb <= wtb_strb;
      end else if (read_valid) begin
         be_addr  <= {replace_addr, offset_t'(beat + 1'b1), {`NBYTES_W{1'b0}}};
      end
   end

endmodule

/* cache_memory.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_memory import cache_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   // Registered front-end request
   input  logic       data_req,
   input  word_addr_t addr_reg,
   input  data_t      wdata_reg,
   input  strb_t      wstrb_reg,
   output data_t      data_rdata,
   output logic       data_ack,
   input  logic       invalidate,
   // Refill channel from the back end
   output logic       replace_req,
   output logic [`ADDR_W-`NBYTES_W-1:`WORD_OFFSET_W] replace_addr,
   input  logic       read_valid,
   input  offset_t    read_offset,
   input  data_t      read_rdata,
   input  logic       replace_done,
   // Write-through buffer head towards the back end
   input  logic       wtb_pop,
   output logic       wtb_empty,
   output logic       wtb_full,
   output data_t      wtb_data,
   output word_addr_t wtb_addr,
   output strb_t      wtb_strb,
   // Events for the counters
   output logic       read_hit,
   output logic       read_miss,
   output logic       write_hit,
   output logic       write_miss
);

   localparam int NLINES = 2**`NLINES_W;
   localparam int NWORDS = 2**`WORD_OFFSET_W;

   mem_state_t state;

   logic [NLINES-1:0] valid;
   tag_t              tag_mem  [NLINES];
   data_t             line_mem [NLINES][NWORDS];

   index_t  idx;
   offset_t offset;
   tag_t    tag;
   logic    hit;
   logic    is_write;
   logic    lookup;
   logic    wtb_push;

   // Address split
   assign offset = addr_reg[`WORD_OFFSET_W-1:0];
   assign idx    = addr_reg[`WORD_OFFSET_W +: `NLINES_W];
   assign tag    = addr_reg[`ADDR_W-`NBYTES_W-1 -: `TAG_W];

   assign hit      = valid[idx] & (tag_mem[idx] == tag);
   assign is_write = |wstrb_reg;
   assign lookup   = data_req & (state == IDLE);   // New request being decided

   assign data_rdata = line_mem[idx][offset];

   // Writes stall only on a full buffer, reads answer on hit or after refill
   assign wtb_push = lookup & is_write & ~wtb_full;
   assign data_ack = (lookup & ~is_write & hit) | wtb_push
                   | (data_req & (state == REFILL_DONE));

   assign read_hit   = lookup & ~is_write & hit;
   assign read_miss  = lookup & ~is_write & ~hit;  // Single cycle, FSM leaves IDLE
   assign write_hit  = wtb_push & hit;
   assign write_miss = wtb_push & ~hit;            // No allocate on write miss

   assign replace_req  = (state == REFILL);
   assign replace_addr = addr_reg[`ADDR_W-`NBYTES_W-1:`WORD_OFFSET_W];

   // Miss sequencing
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:        if (read_miss) state <= DRAIN_WAIT;
            DRAIN_WAIT:  if (wtb_empty) state <= REFILL;  // Memory must be up to date
            REFILL:      if (replace_done) state <= REFILL_DONE;
            REFILL_DONE: state <= IDLE;
            default:     state <= IDLE;
         endcase
      end
   end

   // Valid bits, invalidate wins over a finishing refill
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else if (invalidate) begin
         valid <= '0;
      end else if (replace_req && replace_done) begin
         valid[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (replace_req && replace_done) begin
         tag_mem[idx] <= tag;
      end
   end

   // Line data from refill beats or write hits
   always_ff @(posedge clk) begin
      if (replace_req && read_valid) begin
         line_mem[idx][read_offset] <= read_rdata;
      end else if (wtb_push && hit) begin
         for (int b = 0; b < `NBYTES; b++) begin
            if (wstrb_reg[b]) begin
               line_mem[idx][offset][8*b +: 8] <= wdata_reg[8*b +: 8];
            end
         end
      end
   end

   // Every write goes through
   cache_wtbuf i_wtbuf (
      .clk       (clk),
      .rst       (rst),
      .push      (wtb_push),
      .push_addr (addr_reg),
      .push_data (wdata_reg),
      .push_strb (wstrb_reg),
      .pop       (wtb_pop),
      .empty     (wtb_empty),
      .full      (wtb_full),
      .addr      (wtb_addr),
      .data      (wtb_data),
      .strb      (wtb_strb)
   );

endmodule

/* cache_front_end.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_front_end import cache_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   // Native port from the host
   input  logic       req,
   input  fe_addr_t   addr,
   input  data_t      wdata,
   input  strb_t      wstrb,
   output data_t      rdata,
   output logic       ack,
   // Cache memory side
   input  data_t      data_rdata,
   input  logic       data_ack,
   output logic       data_req,
   output word_addr_t addr_reg,
   output data_t      wdata_reg,
   output strb_t      wstrb_reg,
   // Controller side
   input  data_t      ctrl_rdata,
   input  logic       ctrl_ack,
   output logic       ctrl_req,
   output ctrl_addr_t ctrl_addr
);

   logic busy;
   logic accept;
   logic sel_ctrl;

   assign busy     = data_req | ctrl_req;          // One request in flight
   assign accept   = req & (~busy | ack);          // Next req may overlap the ack cycle
   assign sel_ctrl = addr[`ADDR_W-`NBYTES_W];      // MSB picks the register block

   // Request strobes held until answered
   always_ff @(posedge clk) begin
      if (rst) begin
         data_req <= 1'b0;
         ctrl_req <= 1'b0;
      end else if (accept) begin
         data_req <= ~sel_ctrl;
         ctrl_req <= sel_ctrl;
      end else if (ack) begin
         data_req <= 1'b0;
         ctrl_req <= 1'b0;
      end
   end

   // Request fields, kept stable while the strobe is up
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_reg  <= addr[`ADDR_W-`NBYTES_W-1:0];
         wdata_reg <= wdata;
         wstrb_reg <= wstrb;                       // Zero means read
         ctrl_addr <= addr[`CTRL_ADDR_W-1:0];
      end
   end

   // Only one side can answer at a time
   assign ack   = data_ack | ctrl_ack;
   assign rdata = ctrl_ack ? ctrl_rdata : data_rdata;

endmodule

/* cache_wtbuf.sv */
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_wtbuf import cache_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       push,
   input  word_addr_t push_addr,
   input  data_t      push_data,
   input  strb_t      push_strb,
   input  logic       pop,
   output logic       empty,
   output logic       full,
   output word_addr_t addr,     // Oldest entry
   output data_t      data,
   output strb_t      strb
);

   localparam int DEPTH = 2**`WTBUF_DEPTH_W;

   word_addr_t addr_mem [DEPTH];
   data_t      data_mem [DEPTH];
   strb_t      strb_mem [DEPTH];

   logic [`WTBUF_DEPTH_W-1:0] wr_ptr;
   logic [`WTBUF_DEPTH_W-1:0] rd_ptr;
   logic [`WTBUF_DEPTH_W:0]   count;      // One bit wider to hold DEPTH
   logic                      do_push;
   logic                      do_pop;

   assign empty   = (count == '0);
   assign full    = (count == DEPTH[`WTBUF_DEPTH_W:0]);
   assign do_push = push & ~full;         // Overflow dropped
   assign do_pop  = pop & ~empty;         // Underflow dropped

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Pointers wrap naturally
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         count <= count + do_push - do_pop;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         addr_mem[wr_ptr] <= push_addr;
         data_mem[wr_ptr] <= push_data;
         strb_mem[wr_ptr] <= push_strb;
      end
   end

   assign addr = addr_mem[rd_ptr];
   assign data = data_mem[rd_ptr];
   assign strb = strb_mem[rd_ptr];

endmodule

/* cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

   // Address types
   typedef logic [`ADDR_W-`NBYTES_W-1:0] word_addr_t;  // Word address of data space
   typedef logic [`ADDR_W-`NBYTES_W:0]   fe_addr_t;    // Top bit selects controller

   // Payload
   typedef logic [`DATA_W-1:0] data_t;
   typedef logic [`NBYTES-1:0] strb_t;

   // Line geometry fields
   typedef logic [`TAG_W-1:0]         tag_t;
   typedef logic [`NLINES_W-1:0]      index_t;
   typedef logic [`WORD_OFFSET_W-1:0] offset_t;

   typedef logic [`CTRL_ADDR_W-1:0] ctrl_addr_t;
   typedef logic [`CNT_W-1:0]       cnt_t;

   // Cache memory miss handling
   typedef enum logic [1:0] {
      IDLE,                                   // Serving hits and writes
      DRAIN_WAIT,                             // Read miss, buffer still busy
      REFILL,                                 // Line fetch in progress
      REFILL_DONE                             // Line valid, answer the read
   } mem_state_t;

   // Back-end port owner
   typedef enum logic [1:0] {
      BE_IDLE,
      BE_WRITE,
      BE_READ
   } be_state_t;

endpackage

/* cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Data space geometry
`define ADDR_W        16                 // Byte address width
`define DATA_W        32
`define NBYTES        4                  // Bytes per word
`define NBYTES_W      2
`define NLINES_W      4                  // 16 lines
`define WORD_OFFSET_W 2                  // 4 words per line
`define TAG_W         (`ADDR_W - `NLINES_W - `WORD_OFFSET_W - `NBYTES_W)

`define WTBUF_DEPTH_W 2                  // 4 buffer entries

// Controller register space
`define CTRL_ADDR_W   4
`define CNT_W         32

`define CTRL_READ_HIT   4'd0
`define CTRL_READ_MISS  4'd1
`define CTRL_WRITE_HIT  4'd2
`define CTRL_WRITE_MISS 4'd3
`define CTRL_WTB_EMPTY  4'd4             // Status, read only
`define CTRL_WTB_FULL   4'd5
`define CTRL_RST_CNT    4'd6             // Write clears all counters
`define CTRL_INVALIDATE 4'd7             // Write drops every line

`endif
